// ==== src/weight_r2b_pkg.sv ====
// ##################################################
// weight reorder package
// default matrix sizes and the element, row and tile types
// ##################################################

`default_nettype none

package weight_r2b_pkg;

    // width of one weight element
    localparam int elem_width = 16;

    // matrix dimensions, kept small for short simulations
    localparam int mat_rows = 16;
    localparam int mat_cols = 8;

    // edge of one square output tile
    localparam int block_size = 2;

    // derived widths
    localparam int row_width  = elem_width * mat_cols;
    localparam int tile_slots = block_size * block_size;
    localparam int tile_width = elem_width * tile_slots;

    // one weight element
    typedef logic [elem_width-1:0] elem_t;

    // one packed matrix row, column 0 in the top slot
    typedef logic [row_width-1:0] row_t;

    // one output tile, slot r * block_size + c with slot 0 on top
    typedef logic [tile_width-1:0] tile_t;

endpackage

`default_nettype wire

// ==== src/ram_1w2r.sv ====
// ##################################################
// ram_1w2r
// register array with one write port and two registered reads
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module ram_1w2r #(
    parameter int data_width = 128,
    parameter int depth      = 16
) (
    input  wire                       clk,
    input  wire                       we,
    input  wire  [$clog2(depth)-1:0]  write_addr,
    input  wire  [data_width-1:0]     din,
    input  wire  [$clog2(depth)-1:0]  read_addr0,
    input  wire  [$clog2(depth)-1:0]  read_addr1,
    output logic [data_width-1:0]     dout0,
    output logic [data_width-1:0]     dout1
);

    // storage, no reset on the array
    logic [data_width-1:0] mem [depth];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= din;
        end
    end

    // both reads sample the array before this edge's write
    // so a same-address access returns the old row
    always_ff @(posedge clk) begin
        dout0 <= mem[read_addr0];
        dout1 <= mem[read_addr1];
    end

endmodule

`default_nettype wire

// ==== src/weight_row_packer.sv ====
// ##################################################
// weight row packer
// gathers serial weight elements into full matrix rows
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module weight_row_packer #(
    parameter int elem_width = weight_r2b_pkg::elem_width,
    parameter int mat_cols   = weight_r2b_pkg::mat_cols
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    accept,
    input  wire                    elem_valid,
    input  wire weight_r2b_pkg::elem_t elem_data,
    output logic                   row_valid,
    output weight_r2b_pkg::row_t   row_data
);

    import weight_r2b_pkg::*;

    localparam int row_bits  = elem_width * mat_cols;
    localparam int cnt_width = (mat_cols > 1) ? $clog2(mat_cols) : 1;
    localparam logic [cnt_width-1:0] last_col = cnt_width'(mat_cols - 1);

    // column position of the next element
    logic [cnt_width-1:0] col_cnt;

    // elements of the row being collected, oldest at the top
    row_t shift_reg;

    // the shifted row including the current element
    row_t shift_next;

    logic take;
    logic row_end;

    // strobes outside the accept window are dropped
    assign take    = accept && elem_valid;
    assign row_end = take && (col_cnt == last_col);

    assign shift_next = {shift_reg[row_bits-elem_width-1:0], elem_data};

    // column counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
        end else if (take) begin
            if (col_cnt == last_col) begin
                col_cnt <= '0;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // element shift register, payload only
    always_ff @(posedge clk) begin
        if (take) begin
            shift_reg <= shift_next;
        end
    end

    // completed row is held until the next one finishes
    always_ff @(posedge clk) begin
        if (row_end) begin
            row_data <= shift_next;
        end
    end

    // one-cycle row strobe after the last column
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= row_end;
        end
    end

endmodule

`default_nettype wire

// ==== src/weight_r2b_converter.sv ====
// ##################################################
// weight row to block converter
// buffers the full matrix then emits square tiles, row blocks first
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module weight_r2b_converter #(
    parameter int elem_width = weight_r2b_pkg::elem_width,
    parameter int mat_rows   = weight_r2b_pkg::mat_rows,
    parameter int mat_cols   = weight_r2b_pkg::mat_cols,
    parameter int block_size = weight_r2b_pkg::block_size
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       en,
    input  wire                       row_valid,
    input  wire weight_r2b_pkg::row_t row_data,
    output logic                      filling,
    output logic                      tile_valid,
    output weight_r2b_pkg::tile_t     tile_data,
    output logic                      tile_last,
    output logic                      buffer_done
);

    import weight_r2b_pkg::*;

    // tile geometry
    localparam int row_blocks = mat_rows / block_size;
    localparam int col_groups = mat_cols / block_size;
    localparam int n_slots    = block_size * block_size;

    // counter widths, never zero
    localparam int addr_width = (mat_rows > 1) ? $clog2(mat_rows) : 1;
    localparam int blk_width  = (row_blocks > 1) ? $clog2(row_blocks) : 1;
    localparam int grp_width  = (col_groups > 1) ? $clog2(col_groups) : 1;

    localparam logic [addr_width-1:0] last_row = addr_width'(mat_rows - 1);
    localparam logic [blk_width-1:0]  last_blk = blk_width'(row_blocks - 1);
    localparam logic [grp_width-1:0]  last_grp = grp_width'(col_groups - 1);

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        SLICE,
        DONE
    } state_t;

    state_t state;
    state_t state_next;

    // buffer ports
    logic                  ram_we;
    logic [addr_width-1:0] ram_write_addr;
    logic [addr_width-1:0] ram_read_addr0;
    logic [addr_width-1:0] ram_read_addr1;
    row_t                  ram_dout0;
    row_t                  ram_dout1;

    // rows written so far
    logic [addr_width-1:0] row_cnt;

    // tile index, row block walks fastest
    logic [blk_width-1:0] row_blk;
    logic [grp_width-1:0] col_grp;
    logic                 all_issued;
    logic                 issue;
    logic                 issue_last;

    // read stage, lines up with the buffer outputs
    logic                 rd_valid;
    logic                 rd_last;
    logic [grp_width-1:0] col_grp_d;

    tile_t tile_next;

    // fill side
    assign filling        = (state == FILL) && en;
    assign ram_we         = (state == FILL) && row_valid;
    assign ram_write_addr = row_cnt;

    // slice side
    assign issue      = (state == SLICE) && en && !all_issued;
    assign issue_last = issue && (row_blk == last_blk) && (col_grp == last_grp);

    // two read ports cover one row pair, so a tile is two rows tall
    assign ram_read_addr0 = addr_width'(int'(row_blk) * block_size);
    assign ram_read_addr1 = addr_width'(int'(row_blk) * block_size + 1);

    assign buffer_done = (state == DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (en) begin
                    state_next = FILL;
                end
            end
            FILL: begin
                if (ram_we && (row_cnt == last_row)) begin
                    state_next = SLICE;
                end
            end
            // wait for the final tile to leave the pipeline
            SLICE: begin
                if (tile_last) begin
                    state_next = DONE;
                end
            end
            DONE: state_next = DONE;
            default: state_next = IDLE;
        endcase
    end

    // write address counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (ram_we && (row_cnt != last_row)) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // tile index counters, frozen while en is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_blk    <= '0;
            col_grp    <= '0;
            all_issued <= 1'b0;
        end else if (issue) begin
            if (row_blk == last_blk) begin
                row_blk <= '0;
                if (col_grp == last_grp) begin
                    col_grp    <= '0;
                    all_issued <= 1'b1;
                end else begin
                    col_grp <= col_grp + 1'b1;
                end
            end else begin
                row_blk <= row_blk + 1'b1;
            end
        end
    end

    // strobes drain regardless of en so in-flight tiles still appear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid   <= 1'b0;
            rd_last    <= 1'b0;
            tile_valid <= 1'b0;
            tile_last  <= 1'b0;
        end else begin
            rd_valid   <= issue;
            rd_last    <= issue_last;
            tile_valid <= rd_valid;
            tile_last  <= rd_last;
        end
    end

    // column group travels with the read
    always_ff @(posedge clk) begin
        if (issue) begin
            col_grp_d <= col_grp;
        end
    end

    // pick block_size columns from each row of the pair
    always_comb begin
        tile_next = '0;
        for (int c = 0; c < block_size; c++) begin
            tile_next[(n_slots - 1 - c) * elem_width +: elem_width] =
                ram_dout0[(mat_cols - 1 - int'(col_grp_d) * block_size - c) * elem_width
                          +: elem_width];
            tile_next[(n_slots - 1 - block_size - c) * elem_width +: elem_width] =
                ram_dout1[(mat_cols - 1 - int'(col_grp_d) * block_size - c) * elem_width
                          +: elem_width];
        end
    end

    // tile register
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            tile_data <= tile_next;
        end
    end

    ram_1w2r #(
        .data_width (elem_width * mat_cols),
        .depth      (mat_rows)
    ) weight_buffer_ram (
        .clk        (clk),
        .we         (ram_we),
        .write_addr (ram_write_addr),
        .din        (row_data),
        .read_addr0 (ram_read_addr0),
        .read_addr1 (ram_read_addr1),
        .dout0      (ram_dout0),
        .dout1      (ram_dout1)
    );

endmodule

`default_nettype wire

// ==== src/weight_reorder_top.sv ====
// ##################################################
// weight reorder top
// element stream in, square weight tiles out
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module weight_reorder_top #(
    parameter int elem_width = weight_r2b_pkg::elem_width,
    parameter int mat_rows   = weight_r2b_pkg::mat_rows,
    parameter int mat_cols   = weight_r2b_pkg::mat_cols,
    parameter int block_size = weight_r2b_pkg::block_size
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        en,
    input  wire                        elem_valid,
    input  wire weight_r2b_pkg::elem_t elem_data,
    output logic                       tile_valid,
    output weight_r2b_pkg::tile_t      tile_data,
    output logic                       tile_last,
    output logic                       buffer_done
);

    import weight_r2b_pkg::*;

    // packer to converter
    logic row_valid;
    row_t row_data;
    logic filling;

    weight_row_packer #(
        .elem_width (elem_width),
        .mat_cols   (mat_cols)
    ) weight_row_packer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (filling),
        .elem_valid (elem_valid),
        .elem_data  (elem_data),
        .row_valid  (row_valid),
        .row_data   (row_data)
    );

    weight_r2b_converter #(
        .elem_width  (elem_width),
        .mat_rows    (mat_rows),
        .mat_cols    (mat_cols),
        .block_size  (block_size)
    ) weight_r2b_converter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .row_valid   (row_valid),
        .row_data    (row_data),
        .filling     (filling),
        .tile_valid  (tile_valid),
        .tile_data   (tile_data),
        .tile_last   (tile_last),
        .buffer_done (buffer_done)
    );

endmodule

`default_nettype wire

// ==== bench/weight_reorder_asserts.sv ====
// ##################################################
// weight reorder converter checks
// strobe and state rules, bound into the converter
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module weight_reorder_asserts (
    input wire       clk,
    input wire       rst_n,
    input wire [1:0] state,
    input wire       row_valid,
    input wire       tile_valid,
    input wire       tile_last,
    input wire       buffer_done
);

    // converter state encoding
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_fill = 2'd1;

    // failures seen, read by the testbench at the end of the run
    int assert_fails = 0;

    last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        tile_last |-> tile_valid)
        else begin
            assert_fails++;
            $error("tile_last high without tile_valid");
        end

    // done is sticky until the next reset
    done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        buffer_done |=> buffer_done)
        else begin
            assert_fails++;
            $error("buffer_done fell without a reset");
        end

    no_tile_before_slice: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_idle || state == st_fill) |-> !tile_valid)
        else begin
            assert_fails++;
            $error("tile_valid high while idle or filling");
        end

    row_only_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
        row_valid |-> (state == st_fill))
        else begin
            assert_fails++;
            $error("row_valid high outside the fill state");
        end

endmodule

bind weight_r2b_converter weight_reorder_asserts weight_reorder_asserts_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .row_valid   (row_valid),
    .tile_valid  (tile_valid),
    .tile_last   (tile_last),
    .buffer_done (buffer_done)
);

`default_nettype wire

// ==== bench/tb_weight_reorder.sv ====
// ##################################################
// weight reorder testbench
// directed tests against a stored matrix model
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module tb_weight_reorder;

    import weight_r2b_pkg::*;

    localparam int row_blocks  = mat_rows / block_size;
    localparam int n_tiles     = row_blocks * (mat_cols / block_size);
    localparam int n_slots     = block_size * block_size;
    localparam int n_elems     = mat_rows * mat_cols;
    localparam int max_gap     = 3;
    localparam int max_stall   = 4;
    localparam int hold_cycles = 40;
    localparam int n_tests     = 5;

    // worst case cycles of one test
    localparam int test_len = 5 + n_elems * (max_gap + 1) + n_tiles * (max_stall + 4)
                              + hold_cycles + 20;
    localparam int cycle_limit = 4 * n_tests * test_len;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  en;
    logic  elem_valid;
    elem_t elem_data;
    logic  tile_valid;
    tile_t tile_data;
    logic  tile_last;
    logic  buffer_done;

    elem_t model [mat_rows][mat_cols];

    // monitor results
    tile_t captured[$];
    int    last_idx[$];
    int    done_tiles;
    logic  done_with_last;

    int errors = 0;
    int checks = 0;

    always #10 clk = ~clk;

    weight_reorder_top #(
        .elem_width (elem_width),
        .mat_rows   (mat_rows),
        .mat_cols   (mat_cols),
        .block_size (block_size)
    ) weight_reorder_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .elem_valid  (elem_valid),
        .elem_data   (elem_data),
        .tile_valid  (tile_valid),
        .tile_data   (tile_data),
        .tile_last   (tile_last),
        .buffer_done (buffer_done)
    );

    // tiles and strobes sampled on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (tile_valid) begin
                captured.push_back(tile_data);
                if (tile_last) begin
                    last_idx.push_back(captured.size() - 1);
                    done_with_last = buffer_done;
                end
            end else if (tile_last) begin
                last_idx.push_back(-1);
            end
            if (buffer_done && done_tiles < 0) begin
                done_tiles = captured.size();
            end
        end
    end

    // tile k sits at row block k mod row_blocks and column group k div row_blocks
    function automatic tile_t expected_tile(input int k);
        tile_t t;
        int    rb;
        int    cg;
        t  = '0;
        rb = k % row_blocks;
        cg = k / row_blocks;
        for (int r = 0; r < block_size; r++) begin
            for (int c = 0; c < block_size; c++) begin
                t[(n_slots - 1 - (r * block_size + c)) * elem_width +: elem_width] =
                    model[rb * block_size + r][cg * block_size + c];
            end
        end
        return t;
    endfunction

    task automatic apply_reset;
        rst_n      = 1'b0;
        en         = 1'b0;
        elem_valid = 1'b0;
        elem_data  = '0;
        repeat (5) @(negedge clk);
        captured.delete();
        last_idx.delete();
        done_tiles     = -1;
        done_with_last = 1'b0;
        rst_n          = 1'b1;
    endtask

    task automatic fill_model(input bit random_data);
        for (int r = 0; r < mat_rows; r++) begin
            for (int c = 0; c < mat_cols; c++) begin
                if (random_data) begin
                    model[r][c] = elem_t'($urandom());
                end else begin
                    model[r][c] = elem_t'(r * mat_cols + c);
                end
            end
        end
    endtask

    task automatic send_elem(input elem_t d, input int gap);
        elem_valid = 1'b1;
        elem_data  = d;
        @(negedge clk);
        elem_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // one clock for idle to fill before the row-major stream
    task automatic load_matrix(input int gap_max);
        en = 1'b1;
        @(negedge clk);
        for (int r = 0; r < mat_rows; r++) begin
            for (int c = 0; c < mat_cols; c++) begin
                send_elem(model[r][c], (gap_max == 0) ? 0 : $urandom_range(0, gap_max));
            end
        end
    endtask

    task automatic wait_done;
        int n;
        n = 0;
        while (!buffer_done && n < test_len) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (buffer_done) else begin
            errors++;
            $display("buffer_done did not rise within %0d cycles", test_len);
        end
        // the monitor logs the done edge on the same falling edge
        @(negedge clk);
    endtask

    task automatic stall_until_done;
        int n;
        int k;
        n = 0;
        while (!buffer_done && n < test_len) begin
            en = 1'b0;
            k  = $urandom_range(1, max_stall);
            repeat (k) @(negedge clk);
            en = 1'b1;
            n  = n + k;
            k  = $urandom_range(1, 3);
            repeat (k) @(negedge clk);
            n  = n + k;
        end
        en = 1'b1;
    endtask

    task automatic check_results(input string name);
        $display("checking %s", name);
        checks++;
        assert (captured.size() == n_tiles) else begin
            errors++;
            $display("FAILED t=%0t tile_valid count expected %0d got %0d", $time, n_tiles,
                     captured.size());
        end
        for (int k = 0; k < captured.size() && k < n_tiles; k++) begin
            checks++;
            assert (captured[k] == expected_tile(k)) else begin
                errors++;
                $display("FAILED t=%0t tile_data[%0d] expected %h got %h", $time, k,
                         expected_tile(k), captured[k]);
            end
        end
        checks++;
        assert (last_idx.size() == 1 && last_idx[0] == n_tiles - 1) else begin
            errors++;
            $display("tile_last was not seen on the final tile alone in %s", name);
        end
        checks++;
        assert (done_tiles == n_tiles && !done_with_last) else begin
            errors++;
            $display("buffer_done rose before the final tile in %s", name);
        end
    endtask

    task automatic load_index_matrix;
        apply_reset();
        fill_model(1'b0);
        load_matrix(0);
        wait_done();
        check_results("index matrix");
    endtask

    task automatic load_with_gaps;
        apply_reset();
        fill_model(1'b1);
        load_matrix(max_gap);
        wait_done();
        check_results("random gaps");
    endtask

    task automatic stall_during_slice;
        apply_reset();
        fill_model(1'b1);
        load_matrix(0);
        stall_until_done();
        wait_done();
        check_results("slice stalls");
    endtask

    // done must hold with no extra tiles
    task automatic hold_done_state;
        apply_reset();
        fill_model(1'b1);
        load_matrix(1);
        wait_done();
        check_results("done hold");
        repeat (hold_cycles) begin
            @(negedge clk);
            checks++;
            assert (buffer_done && captured.size() == n_tiles) else begin
                errors++;
                $display("done state lost or extra tile after done");
            end
        end
    endtask

    task automatic ignore_early_strobes;
        apply_reset();
        fill_model(1'b1);
        for (int i = 0; i < 2 * mat_cols + 3; i++) begin
            send_elem(elem_t'(16'hdead ^ i), 0);
        end
        load_matrix(0);
        wait_done();
        check_results("early strobes");
    endtask

    // hung run guard
    initial begin : watchdog
        repeat (cycle_limit) @(posedge clk);
        $display("timeout after %0d cycles", cycle_limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h6686c733));
        load_index_matrix();
        load_with_gaps();
        stall_during_slice();
        hold_done_state();
        ignore_early_strobes();
        checks++;
        assert (weight_reorder_top_inst.weight_r2b_converter_inst
                .weight_reorder_asserts_inst.assert_fails == 0) else begin
            errors++;
            $display("concurrent assertions failed in the converter");
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/weight_r2b_pkg.sv
src/ram_1w2r.sv
src/weight_row_packer.sv
src/weight_r2b_converter.sv
src/weight_reorder_top.sv
bench/weight_reorder_asserts.sv
bench/tb_weight_reorder.sv

// ==== Makefile ====
# Verilator build and run for the weight reorder testbench

VERILATOR ?= verilator
TOP       ?= tb_weight_reorder
RTL_TOP   ?= weight_reorder_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timing
SIMARGS   ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides pass or fail
run: build
	$(BUILD_DIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "All checks passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale 1ns/1ps \
		src/weight_r2b_pkg.sv src/ram_1w2r.sv src/weight_row_packer.sv \
		src/weight_r2b_converter.sv src/weight_reorder_top.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
